// ==== build.f ====
hw/bt_init_pkg.sv
hw/bt_cmd_sender.sv
hw/bt_resp_reader.sv
hw/bt_init_seq.sv
hw/bt_init_top.sv
tb/bt_init_checker.sv
tb/tb_bt_init.sv

// ==== Bender.yml ====
package:
  name: bt_init

sources:
  - hw/bt_init_pkg.sv
  - hw/bt_cmd_sender.sv
  - hw/bt_resp_reader.sv
  - hw/bt_init_seq.sv
  - hw/bt_init_top.sv
  - target: test
    files:
      - tb/bt_init_checker.sv
      - tb/tb_bt_init.sv

// ==== tb/tb_bt_init.sv ====
`timescale 1ns/100ps

module tb_bt_init
	import bt_init_pkg::*;
();

	localparam int CLK_PERIOD     = 20;
	localparam int HOLD_CYCLES    = 20;	// normal mode watched this long
	localparam int MAX_FAILS      = 8;
	localparam int ROUND_CYCLES   = CMD_MAX_BYTES + 64 + 4*RESP_BYTES + 16;
	localparam int TIMEOUT_CYCLES =
		2 * (PWRUP_CYCLES + BAKNOR_CYCLES + HOLD_CYCLES + 4*5*ROUND_CYCLES);

	logic                 clk;
	logic                 rst_n;
	req_byte_t            req_o;
	logic [SURPLUS_W-1:0] req_surplus_i;
	logic                 resp_rd_o;
	logic                 resp_empty_i;
	resp_byte_t           resp_i;
	bt_pins_t             pins_o;
	logic                 init_done_o;
	logic                 end_run;
	logic                 report_done;
	int                   fail_cnt;
	logic [31:0]          lfsr_state = 32'ha6a8;
	logic [BYTE_W-1:0]    resp_q [$];	// response fifo contents
	logic [15:0]          req_tail;		// last two request bytes
	int                   hold_cnt;
	int                   fails_sent;

	bt_init_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_o         (req_o),
		.req_surplus_i (req_surplus_i),
		.resp_rd_o     (resp_rd_o),
		.resp_empty_i  (resp_empty_i),
		.resp_i        (resp_i),
		.pins_o        (pins_o),
		.init_done_o   (init_done_o)
	);

	bt_init_checker u_chk (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_i         (req_o),
		.req_surplus_i (req_surplus_i),
		.resp_rd_i     (resp_rd_o),
		.resp_empty_i  (resp_empty_i),
		.resp_i        (resp_i),
		.pins_i        (pins_o),
		.init_done_i   (init_done_o),
		.end_i         (end_run),
		.report_done_o (report_done),
		.fail_cnt_o    (fail_cnt)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v          = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// OK, or now and then OK with one bit flipped
	task automatic queue_response();
		logic [31:0]                  r;
		logic [31:0]                  pos;
		logic [31:0]                  bit_sel;
		logic [RESP_BYTES*BYTE_W-1:0] word;
		word = RESP_OK;
		take_bits(1, r);
		if (r[0] && fails_sent < MAX_FAILS)
		begin
			take_bits(2, pos);
			take_bits(3, bit_sel);
			word = word ^ (32'd1 << (pos[1:0]*BYTE_W + bit_sel[2:0]));
			fails_sent++;
		end
		for (int i = RESP_BYTES - 1; i >= 0; i--)
		begin
			resp_q.push_back(word[i*BYTE_W +: BYTE_W]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk)
	begin : fifo_model
		logic [31:0] r;
		if (hold_cnt == 0)
		begin
			take_bits(SURPLUS_W, r);
			req_surplus_i <= r[SURPLUS_W-1:0];
			take_bits(3, r);
			hold_cnt = r[2:0];	// keep for 1 to 8 cycles
		end
		else
		begin
			hold_cnt--;
		end
		if (req_o.vld === 1'b1)
		begin
			req_tail = {req_tail[7:0], req_o.data};
			if (req_tail == 16'h0d0a)	// CR LF closes a command
			begin
				queue_response();
				req_tail = '0;
			end
		end
		resp_i.vld <= 1'b0;
		if (resp_rd_o === 1'b1 && resp_q.size() > 0)
		begin
			resp_i.data <= resp_q.pop_front();
			resp_i.vld  <= 1'b1;
		end
		resp_empty_i <= (resp_q.size() == 0);
	end

	initial
	begin
		rst_n         = 1'b0;
		req_surplus_i = '0;
		resp_empty_i  = 1'b1;
		resp_i        = '0;
		end_run       = 1'b0;
		req_tail      = '0;
		hold_cnt      = 0;
		fails_sent    = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait (init_done_o === 1'b1);
		repeat (HOLD_CYCLES) @(posedge clk);
		end_run <= 1'b1;
		wait (report_done === 1'b1);
		$display("altered responses sent: %0d", fails_sent);
		if (fail_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: init_done_o not reached and reported within %0d cycles",
			TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb/bt_init_checker.sv ====
`timescale 1ns/100ps

module bt_init_checker
	import bt_init_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  req_byte_t            req_i,
	input  logic [SURPLUS_W-1:0] req_surplus_i,
	input  logic                 resp_rd_i,
	input  logic                 resp_empty_i,
	input  resp_byte_t           resp_i,
	input  bt_pins_t             pins_i,
	input  logic                 init_done_i,
	input  logic                 end_i,
	output logic                 report_done_o,
	output int                   fail_cnt_o
);

	at_cmd_e     exp_cmd;
	logic [31:0] resp_word;
	logic        key_seen;
	logic        in_cmd;
	logic        room_seen;	// surplus was big enough since the last response
	logic        role_ok;
	logic        normal;
	int          cyc;
	int          byte_idx;
	int          resp_n;
	int          rd_n;		// reads in the current response
	int          retries;
	int          vcc_low_n;
	int          checks = 0;
	int          errors;
	int          failing;
	int          test_err [1:5] = '{default: 0};

	task automatic compare_value(input int t, input string name,
	                             input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			test_err[t]++;
			$display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic flag_error(input int t, input string msg);
		checks++;
		test_err[t]++;
		$display("error at %0d ns: %s", $time, msg);
	endtask

	task automatic print_result(input int t, input string what);
		$display("test %0d %s: %s", t, what, (test_err[t] == 0) ? "pass" : "fail");
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_cmd       = CMD_CMODE;
			key_seen      = 1'b0;
			in_cmd        = 1'b0;
			room_seen     = 1'b0;
			role_ok       = 1'b0;
			normal        = 1'b0;
			cyc           = 0;
			resp_n        = 0;
			rd_n          = 0;
			retries       = 0;
			vcc_low_n     = 0;
			report_done_o <= 1'b0;
			fail_cnt_o    <= 0;
		end
		else
		begin
			if (cyc == 0)
				compare_value(1, "{vld,rd,done,key,vcc}", 5'b00001,
					{req_i.vld, resp_rd_i, init_done_i, pins_i.key, pins_i.vcc});
			if (!key_seen && pins_i.key)
			begin
				key_seen  = 1'b1;
				room_seen = 1'b0;
				compare_value(1, "cycles to key rise", PWRUP_CYCLES, cyc);
				print_result(1, "reset values and key timing");
			end
			cyc++;

			// request bytes, byte 3 tells which command it is
			if (req_i.vld)
			begin
				if (!in_cmd)
				begin
					in_cmd   = 1'b1;
					byte_idx = 0;
					if (role_ok)
						flag_error(3, "command sent after ROLE was accepted");
					if (!room_seen)
						flag_error(2, "command started while surplus was below its length");
				end
				if (byte_idx < CMD_MAX_BYTES)
					compare_value((byte_idx == 3) ? 3 : 2, "req_o.data",
						CMD_TEXT[exp_cmd][(CMD_MAX_BYTES - byte_idx)*BYTE_W - 1 -: BYTE_W],
						req_i.data);
				byte_idx++;
			end
			else if (in_cmd)
			begin
				in_cmd = 1'b0;
				compare_value(2, "command length", CMD_LEN[exp_cmd], byte_idx);
			end

			if (resp_rd_i)
			begin
				rd_n++;
				if (resp_empty_i)
					flag_error(4, "read-enable while the response FIFO was empty");
			end
			if (resp_i.vld)
			begin
				resp_word = {resp_word[23:0], resp_i.data};
				resp_n++;
				if (resp_n == RESP_BYTES)
				begin
					compare_value(4, "reads per response", RESP_BYTES, rd_n);
					resp_n    = 0;
					rd_n      = 0;
					room_seen = 1'b0;
					if (resp_word != RESP_OK)
						retries++;	// same command again
					else if (exp_cmd != CMD_ROLE)
						exp_cmd = at_cmd_e'(exp_cmd + 1'b1);
					else
					begin
						role_ok = 1'b1;
						print_result(2, "command bytes and room");
						$display("test 3 command order: %s (%0d retries)",
							(test_err[3] == 0) ? "pass" : "fail", retries);
					end
				end
			end
			if (req_surplus_i >= CMD_LEN[exp_cmd])
				room_seen = 1'b1;

			// back to normal mode
			if (role_ok && !normal)
			begin
				if (!pins_i.vcc)
					vcc_low_n++;
				else if (vcc_low_n > 0)
				begin
					normal = 1'b1;
					compare_value(5, "vcc low cycles", BAKNOR_CYCLES, vcc_low_n);
				end
			end
			else if (!role_ok && !pins_i.vcc)
				flag_error(5, "vcc fell before ROLE was accepted");
			if (normal)
				compare_value(5, "{key,vcc,done}", 3'b011,
					{pins_i.key, pins_i.vcc, init_done_i});
			else if (init_done_i)
				flag_error(5, "init_done_o rose before normal mode");

			if (end_i && !report_done_o)
			begin
				if (!role_ok)
				begin
					flag_error(3, "ROLE command was never accepted");
					print_result(2, "command bytes and room");
					print_result(3, "command order");
				end
				compare_value(4, "reads after the last response", 0, rd_n);
				if (!normal)
					flag_error(5, "normal mode was never reached");
				print_result(4, "read-enable rules");
				print_result(5, "back to normal mode");
				errors  = 0;
				failing = 0;
				for (int t = 1; t <= 5; t++)
				begin
					errors += test_err[t];
					if (test_err[t] != 0)
						failing++;
				end
				$display("5 tests, %0d failing, %0d checks, %0d errors", failing, checks, errors);
				fail_cnt_o    <= errors;
				report_done_o <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/bt_init_top.sv ====
`timescale 1ns/100ps

module bt_init_top
	import bt_init_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	output req_byte_t            req_o,
	input  logic [SURPLUS_W-1:0] req_surplus_i,
	output logic                 resp_rd_o,
	input  logic                 resp_empty_i,
	input  resp_byte_t           resp_i,
	output bt_pins_t             pins_o,
	output logic                 init_done_o
);

	logic    send_start;	// seq -> sender
	at_cmd_e send_cmd;
	logic    send_done;
	logic    rx_start;		// seq -> reader
	logic    rx_done;
	logic    rx_ok;

	bt_cmd_sender u_sender (
		.clk           (clk),
		.rst_n         (rst_n),
		.send_start_i  (send_start),
		.send_cmd_i    (send_cmd),
		.req_surplus_i (req_surplus_i),
		.req_o         (req_o),
		.send_done_o   (send_done)
	);

	bt_resp_reader u_reader (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_start_i   (rx_start),
		.resp_empty_i (resp_empty_i),
		.resp_i       (resp_i),
		.resp_rd_o    (resp_rd_o),
		.rx_done_o    (rx_done),
		.rx_ok_o      (rx_ok)
	);

	bt_init_seq u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.send_done_i  (send_done),
		.rx_done_i    (rx_done),
		.rx_ok_i      (rx_ok),
		.send_start_o (send_start),
		.send_cmd_o   (send_cmd),
		.rx_start_o   (rx_start),
		.pins_o       (pins_o),
		.init_done_o  (init_done_o)
	);

endmodule

// ==== hw/bt_init_seq.sv ====
`timescale 1ns/100ps

module bt_init_seq
	import bt_init_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     send_done_i,
	input  logic     rx_done_i,
	input  logic     rx_ok_i,
	output logic     send_start_o,
	output at_cmd_e  send_cmd_o,
	output logic     rx_start_o,
	output bt_pins_t pins_o,
	output logic     init_done_o
);

	seq_state_e                        state;
	at_cmd_e                           cmd;
	logic [$clog2(PWRUP_CYCLES)-1:0]   timer;	// shared by power-up and back-to-normal

	assign send_cmd_o = cmd;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state        <= ST_PWRUP;
			cmd          <= CMD_CMODE;
			timer        <= '0;
			send_start_o <= 1'b0;
			rx_start_o   <= 1'b0;
			pins_o.key   <= 1'b0;
			pins_o.vcc   <= 1'b1;
			init_done_o  <= 1'b0;
		end
		else
		begin
			send_start_o <= 1'b0;
			rx_start_o   <= 1'b0;
			unique case (state)
				ST_PWRUP:
				begin
					timer <= timer + 1'b1;
					if (timer == $bits(timer)'(PWRUP_CYCLES - 1))
					begin
						pins_o.key   <= 1'b1;	// enter AT mode
						cmd          <= CMD_CMODE;
						send_start_o <= 1'b1;
						state        <= ST_SEND;
					end
				end
				ST_SEND:
				begin
					if (send_done_i)
					begin
						rx_start_o <= 1'b1;
						state      <= ST_WAIT;
					end
				end
				ST_WAIT:
				begin
					if (rx_done_i)
					begin
						if (!rx_ok_i)
						begin
							// retry same command
							send_start_o <= 1'b1;
							state        <= ST_SEND;
						end
						else if (cmd == CMD_ROLE)
						begin
							pins_o.vcc <= 1'b0;	// power cycle the module
							timer      <= '0;
							state      <= ST_BAKNOR;
						end
						else
						begin
							cmd          <= at_cmd_e'(cmd + 1'b1);
							send_start_o <= 1'b1;
							state        <= ST_SEND;
						end
					end
				end
				ST_BAKNOR:
				begin
					timer <= timer + 1'b1;
					if (timer == $bits(timer)'(BAKNOR_CYCLES - 1))
					begin
						pins_o.vcc  <= 1'b1;
						pins_o.key  <= 1'b0;	// normal mode
						init_done_o <= 1'b1;
						state       <= ST_DONE;
					end
				end
				ST_DONE:
				begin
					// parked until reset
				end
				default:
				begin
					state <= ST_PWRUP;
					timer <= '0;
				end
			endcase
		end
	end

	// done is sticky, and normal-mode pins stay put with it
	a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		init_done_o |=> init_done_o && pins_o.vcc && !pins_o.key);

endmodule

// ==== hw/bt_resp_reader.sv ====
`timescale 1ns/100ps

module bt_resp_reader
	import bt_init_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_start_i,
	input  logic       resp_empty_i,
	input  resp_byte_t resp_i,
	output logic       resp_rd_o,
	output logic       rx_done_o,
	output logic       rx_ok_o
);

	logic [$clog2(RESP_BYTES+1)-1:0] rd_cnt;	// reads issued
	logic [$clog2(RESP_BYTES+1)-1:0] rx_cnt;	// bytes received
	logic [RESP_BYTES*BYTE_W-1:0]    resp_sh;
	logic [RESP_BYTES*BYTE_W-1:0]    resp_next;
	logic                            active;
	logic                            rd_ok;
	logic                            last_byte;

	assign resp_next = {resp_sh[RESP_BYTES*BYTE_W-BYTE_W-1:0], resp_i.data};

	// reads are spaced one idle cycle apart so empty is always fresh
	assign rd_ok     = active && !resp_empty_i && !resp_rd_o &&
	                   (rd_cnt < $bits(rd_cnt)'(RESP_BYTES));
	assign last_byte = active && resp_i.vld &&
	                   (rx_cnt == $bits(rx_cnt)'(RESP_BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (active && resp_i.vld)
		begin
			resp_sh <= resp_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active    <= 1'b0;
			rd_cnt    <= '0;
			rx_cnt    <= '0;
			resp_rd_o <= 1'b0;
			rx_done_o <= 1'b0;
			rx_ok_o   <= 1'b0;
		end
		else
		begin
			resp_rd_o <= rd_ok;
			rx_done_o <= 1'b0;
			if (rx_start_i)
			begin
				active <= 1'b1;
				rd_cnt <= '0;
				rx_cnt <= '0;
			end
			else if (active)
			begin
				if (rd_ok)
				begin
					rd_cnt <= rd_cnt + 1'b1;
				end
				if (resp_i.vld)
				begin
					rx_cnt <= rx_cnt + 1'b1;
				end
				if (last_byte)
				begin
					active    <= 1'b0;
					rx_done_o <= 1'b1;
					rx_ok_o   <= (resp_next == RESP_OK);	// judged incl. the 4th byte
				end
			end
		end
	end

	// the fifo only drains through our reads, so empty never rises under a read
	a_rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		resp_rd_o |-> !resp_empty_i);

endmodule

// ==== hw/bt_cmd_sender.sv ====
`timescale 1ns/100ps

module bt_cmd_sender
	import bt_init_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 send_start_i,
	input  at_cmd_e              send_cmd_i,
	input  logic [SURPLUS_W-1:0] req_surplus_i,
	output req_byte_t            req_o,
	output logic                 send_done_o
);

	logic [CMD_MAX_BYTES*BYTE_W-1:0] cmd_sh;	// next byte sits on top
	logic [CMD_LEN_W-1:0]            cmd_len;
	logic [CMD_LEN_W-1:0]            byte_cnt;
	logic                            waiting;	// loaded, no room yet
	logic                            sending;
	logic                            start_ok;
	logic                            room_ok;
	logic                            emit;
	logic [BYTE_W-1:0]               req_data;
	logic                            req_vld;

	assign start_ok = send_start_i && !waiting && !sending;
	assign room_ok  = waiting && (CMD_LEN_W'(req_surplus_i) >= cmd_len);
	assign emit     = sending && (byte_cnt < cmd_len);

	// command text and outgoing byte
	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			cmd_sh  <= CMD_TEXT[send_cmd_i];
			cmd_len <= CMD_LEN[send_cmd_i];
		end
		else if (emit)
		begin
			req_data <= cmd_sh[CMD_MAX_BYTES*BYTE_W-1 -: BYTE_W];
			cmd_sh   <= {cmd_sh[CMD_MAX_BYTES*BYTE_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			waiting     <= 1'b0;
			sending     <= 1'b0;
			byte_cnt    <= '0;
			req_vld     <= 1'b0;
			send_done_o <= 1'b0;
		end
		else
		begin
			req_vld     <= emit;
			send_done_o <= 1'b0;
			if (start_ok)
			begin
				waiting  <= 1'b1;
				byte_cnt <= '0;
			end
			else if (room_ok)	// room checked only before the first byte
			begin
				waiting <= 1'b0;
				sending <= 1'b1;
			end
			else if (emit)
			begin
				byte_cnt <= byte_cnt + CMD_LEN_W'(1);
			end
			else if (sending)
			begin
				// last byte went out on the previous edge
				sending     <= 1'b0;
				send_done_o <= 1'b1;
			end
		end
	end

	assign req_o = '{data: req_data, vld: req_vld};

	// a command burst is bounded by the longest string
	a_vld_burst: assert property (@(posedge clk) disable iff (!rst_n)
		req_vld [*CMD_MAX_BYTES] |=> !req_vld);

endmodule

// ==== hw/bt_init_pkg.sv ====
package bt_init_pkg;

	// fifo widths
	localparam int BYTE_W        = 8;
	localparam int SURPLUS_W     = 5;	// request fifo free room count

	// command geometry
	localparam int CMD_MAX_BYTES = 18;
	localparam int CMD_LEN_W     = 6;

	// response check
	localparam int RESP_BYTES = 4;
	localparam logic [RESP_BYTES*BYTE_W-1:0] RESP_OK = 32'h4f_4b_0d_0a;	// "OK\r\n"

	// power sequencing, in clk cycles
	localparam int PWRUP_CYCLES  = 64;	// key low after power-up
	localparam int BAKNOR_CYCLES = 63;	// vcc low before normal mode

	typedef enum logic [1:0] {
		CMD_CMODE = 2'd0,
		CMD_PSWD  = 2'd1,
		CMD_UART  = 2'd2,
		CMD_ROLE  = 2'd3
	} at_cmd_e;

	typedef enum logic [2:0] {
		ST_PWRUP  = 3'd0,
		ST_SEND   = 3'd1,
		ST_WAIT   = 3'd2,
		ST_BAKNOR = 3'd3,
		ST_DONE   = 3'd4
	} seq_state_e;

	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic              vld;
	} req_byte_t;

	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic              vld;
	} resp_byte_t;

	typedef struct packed {
		logic key;	// high selects AT mode
		logic vcc;
	} bt_pins_t;

	// command strings, first character in the top byte, zero padded
	localparam logic [3:0][CMD_MAX_BYTES*BYTE_W-1:0] CMD_TEXT = {
		144'h41_54_2b_52_4f_4c_45_3d_31_0d_0a_00_00_00_00_00_00_00,	// AT+ROLE=1
		144'h41_54_2b_55_41_52_54_3d_39_36_30_30_2c_30_2c_30_0d_0a,	// AT+UART=9600,0,0
		144'h41_54_2b_50_53_57_44_3d_31_32_33_34_0d_0a_00_00_00_00,	// AT+PSWD=1234
		144'h41_54_2b_43_4d_4f_44_45_3d_31_0d_0a_00_00_00_00_00_00	// AT+CMODE=1
	};

	// lengths incl. CR LF, indexed by at_cmd_e
	localparam logic [3:0][CMD_LEN_W-1:0] CMD_LEN = {
		6'd11,
		6'd18,
		6'd14,
		6'd12
	};

endpackage
